/* verilog/noc_pkg.sv */
`default_nettype none

package noc_pkg;

    localparam int FLIT_W     = 16;
    localparam int HDR_W      = 6;
    localparam int PAYLOAD_W  = FLIT_W - HDR_W;
    localparam int NUM_NODES  = 4;
    localparam int FIFO_DEPTH = 8;

    typedef logic [FLIT_W-1:0]            flit_t;
    // 4-bit group above a 2-bit leaf
    typedef logic [HDR_W-1:0]             route_addr_t;
    typedef logic [HDR_W-1:0]             gpu_id_t;
    typedef logic [$clog2(NUM_NODES)-1:0] node_idx_t;

    // Node 0 is GPU 9, the rest follow in order
    localparam gpu_id_t BASE_GPU_ID = 6'd9;

    // GPU IDs 1 to 32 sit at addresses 4 to 35
    function automatic route_addr_t to_route_addr(input gpu_id_t id);
        if (id >= 6'd1 && id <= 6'd32) begin
            return id + 6'd3;
        end
        return '0;
    endfunction

    function automatic gpu_id_t to_gpu_id(input route_addr_t addr);
        if (addr >= 6'd4 && addr <= 6'd35) begin
            return addr - 6'd3;
        end
        return '0;
    endfunction

endpackage

`default_nettype wire

/* verilog/node_link_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface node_link_if;

    // Transmit request from the node towards the bus
    logic                tx_valid;
    noc_pkg::flit_t      tx_data;
    logic                tx_ready;

    // Shared bus, same value on every link
    logic                bus_valid;
    noc_pkg::flit_t      bus_data;

    // Receive side claim of the current bus flit
    logic                rx_match;
    logic                rx_ready;

    modport ni (
        output tx_valid,
        output tx_data,
        input  tx_ready,
        input  bus_valid,
        input  bus_data,
        output rx_match,
        output rx_ready
    );

    modport arb (
        input  tx_valid,
        input  tx_data,
        output tx_ready,
        output bus_valid,
        output bus_data,
        input  rx_match,
        input  rx_ready
    );

endinterface

`default_nettype wire

/* verilog/flit_fifo.sv */
`timescale 1ns/100ps
`default_nettype none

module flit_fifo (
    input  wire logic           clk,
    input  wire logic           reset,
    input  noc_pkg::flit_t      in_data,
    input  wire logic           in_valid,
    output logic                in_ready,
    output noc_pkg::flit_t      out_data,
    output logic                out_valid,
    input  wire logic           out_ready
);

    noc_pkg::flit_t mem [noc_pkg::FIFO_DEPTH];

    logic [$clog2(noc_pkg::FIFO_DEPTH)-1:0]   wr_ptr;
    logic [$clog2(noc_pkg::FIFO_DEPTH)-1:0]   rd_ptr;
    logic [$clog2(noc_pkg::FIFO_DEPTH+1)-1:0] count;

    logic wr_en;
    logic rd_en;

    assign in_ready  = (count != noc_pkg::FIFO_DEPTH);
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];

    assign wr_en = in_valid && in_ready;
    assign rd_en = out_valid && out_ready;

    // Storage has no reset, only the pointers do
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == noc_pkg::FIFO_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == noc_pkg::FIFO_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop keep the count
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/gpu_ni.sv */
`timescale 1ns/100ps
`default_nettype none

module gpu_ni #(
    parameter noc_pkg::gpu_id_t node_id = noc_pkg::BASE_GPU_ID
) (
    input  wire logic           clk,
    input  wire logic           reset,

    // GPU transmit side
    input  noc_pkg::flit_t      gpu_tx_data,
    input  wire logic           gpu_tx_valid,
    output logic                gpu_tx_ready,

    // GPU receive side
    output noc_pkg::flit_t      gpu_rx_data,
    output logic                gpu_rx_valid,
    input  wire logic           gpu_rx_ready,

    node_link_if.ni             link
);

    localparam noc_pkg::route_addr_t own_addr = noc_pkg::to_route_addr(node_id);

    noc_pkg::gpu_id_t      tx_dest_id;
    noc_pkg::route_addr_t  tx_addr;
    noc_pkg::flit_t        tx_flit;

    noc_pkg::route_addr_t  bus_hdr;
    noc_pkg::gpu_id_t      rx_src_id;
    noc_pkg::flit_t        rx_flit;
    logic                  rx_push;
    logic                  rx_room;

    // Outbound: destination GPU ID becomes the routing address
    assign tx_dest_id = gpu_tx_data[noc_pkg::FLIT_W-1 -: noc_pkg::HDR_W];
    assign tx_addr    = noc_pkg::to_route_addr(tx_dest_id);
    assign tx_flit    = {tx_addr, gpu_tx_data[noc_pkg::PAYLOAD_W-1:0]};

    flit_fifo tx_fifo_inst (
        .clk       (clk),
        .reset     (reset),
        .in_data   (tx_flit),
        .in_valid  (gpu_tx_valid),
        .in_ready  (gpu_tx_ready),
        .out_data  (link.tx_data),
        .out_valid (link.tx_valid),
        .out_ready (link.tx_ready)
    );

    // Inbound: claim bus flits carrying our own address
    assign bus_hdr       = link.bus_data[noc_pkg::FLIT_W-1 -: noc_pkg::HDR_W];
    assign link.rx_match = (bus_hdr == own_addr);
    assign link.rx_ready = rx_room;

    // Header goes back to a GPU ID before it reaches the GPU
    assign rx_src_id = noc_pkg::to_gpu_id(bus_hdr);
    assign rx_flit   = {rx_src_id, link.bus_data[noc_pkg::PAYLOAD_W-1:0]};

    // Push happens exactly when the arbiter sees the transfer complete
    assign rx_push = link.bus_valid && link.rx_match;

    flit_fifo rx_fifo_inst (
        .clk       (clk),
        .reset     (reset),
        .in_data   (rx_flit),
        .in_valid  (rx_push),
        .in_ready  (rx_room),
        .out_data  (gpu_rx_data),
        .out_valid (gpu_rx_valid),
        .out_ready (gpu_rx_ready)
    );

endmodule

`default_nettype wire

/* verilog/bus_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module bus_arbiter (
    input  wire logic   clk,
    input  wire logic   reset,
    node_link_if.arb    links [noc_pkg::NUM_NODES],
    output logic [15:0] drop_count
);

    logic [noc_pkg::NUM_NODES-1:0] req;
    logic [noc_pkg::NUM_NODES-1:0] match;
    logic [noc_pkg::NUM_NODES-1:0] ready;
    noc_pkg::flit_t                req_data [noc_pkg::NUM_NODES];

    noc_pkg::node_idx_t ptr;
    noc_pkg::node_idx_t grant;
    logic               bus_valid;
    noc_pkg::flit_t     bus_data;
    logic               complete;
    logic               drop;

    // Search starts at the pointer, first requester wins
    always_comb begin
        noc_pkg::node_idx_t cand;
        grant     = ptr;
        bus_valid = 1'b0;
        for (int off = 0; off < noc_pkg::NUM_NODES; off++) begin
            cand = ptr + noc_pkg::node_idx_t'(off);
            if (!bus_valid && req[cand]) begin
                grant     = cand;
                bus_valid = 1'b1;
            end
        end
    end

    assign bus_data = req_data[grant];

    // Unclaimed flits complete at once and are counted as drops
    assign drop     = bus_valid && (match == '0);
    assign complete = drop || (bus_valid && ((match & ready) != '0));

    for (genvar g = 0; g < noc_pkg::NUM_NODES; g++) begin : g_link
        assign req[g]             = links[g].tx_valid;
        assign req_data[g]        = links[g].tx_data;
        assign match[g]           = links[g].rx_match;
        assign ready[g]           = links[g].rx_ready;
        assign links[g].bus_valid = bus_valid;
        assign links[g].bus_data  = bus_data;
        assign links[g].tx_ready  = complete && (grant == noc_pkg::node_idx_t'(g));
    end

    // A stalled winner keeps top priority, so the grant holds
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ptr <= '0;
        end else if (complete) begin
            ptr <= grant + 1'b1;
        end else if (bus_valid) begin
            ptr <= grant;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            drop_count <= '0;
        end else if (drop && drop_count != '1) begin
            drop_count <= drop_count + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* verilog/gpu_cluster.sv */
`timescale 1ns/100ps
`default_nettype none

module gpu_cluster (
    input  wire logic                                     clk,
    input  wire logic                                     reset,

    // One flit lane per node, node 0 in the low bits
    input  noc_pkg::flit_t [noc_pkg::NUM_NODES-1:0]       gpu_tx_data,
    input  wire logic      [noc_pkg::NUM_NODES-1:0]       gpu_tx_valid,
    output logic           [noc_pkg::NUM_NODES-1:0]       gpu_tx_ready,

    output noc_pkg::flit_t [noc_pkg::NUM_NODES-1:0]       gpu_rx_data,
    output logic           [noc_pkg::NUM_NODES-1:0]       gpu_rx_valid,
    input  wire logic      [noc_pkg::NUM_NODES-1:0]       gpu_rx_ready,

    output logic           [15:0]                         drop_count
);

    node_link_if link [noc_pkg::NUM_NODES] ();

    // Node g is GPU BASE_GPU_ID + g
    for (genvar g = 0; g < noc_pkg::NUM_NODES; g++) begin : g_node
        gpu_ni #(
            .node_id (noc_pkg::gpu_id_t'(noc_pkg::BASE_GPU_ID + g))
        ) gpu_ni_inst (
            .clk          (clk),
            .reset        (reset),
            .gpu_tx_data  (gpu_tx_data[g]),
            .gpu_tx_valid (gpu_tx_valid[g]),
            .gpu_tx_ready (gpu_tx_ready[g]),
            .gpu_rx_data  (gpu_rx_data[g]),
            .gpu_rx_valid (gpu_rx_valid[g]),
            .gpu_rx_ready (gpu_rx_ready[g]),
            .link         (link[g])
        );
    end

    bus_arbiter bus_arbiter_inst (
        .clk        (clk),
        .reset      (reset),
        .links      (link),
        .drop_count (drop_count)
    );

endmodule

`default_nettype wire

/* testbench/cluster_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module cluster_checker (
    input  wire logic                                 clk,
    input  wire logic                                 reset,
    input  noc_pkg::flit_t [noc_pkg::NUM_NODES-1:0]   gpu_tx_data,
    input  wire logic      [noc_pkg::NUM_NODES-1:0]   gpu_tx_valid,
    input  wire logic      [noc_pkg::NUM_NODES-1:0]   gpu_tx_ready,
    input  noc_pkg::flit_t [noc_pkg::NUM_NODES-1:0]   gpu_rx_data,
    input  wire logic      [noc_pkg::NUM_NODES-1:0]   gpu_rx_valid,
    input  wire logic      [noc_pkg::NUM_NODES-1:0]   gpu_rx_ready,
    input  wire logic      [15:0]                     drop_count,
    output int                                        pending,
    output int                                        check_count,
    output int                                        error_count
);

    // Expected flits per destination and source
    noc_pkg::flit_t expected_q [noc_pkg::NUM_NODES][noc_pkg::NUM_NODES][$];
    int             exp_drops;
    bit             stall_seen;
    bit             fair_en;
    int             fair_dst;
    logic [1:0]     fair_window [$];

    initial begin
        pending     = 0;
        check_count = 0;
        error_count = 0;
        exp_drops   = 0;
        stall_seen  = 1'b0;
        fair_en     = 1'b0;
        fair_dst    = 0;
    end

    // GPU IDs 1 to 32 route to address ID+3, anything else to address 0
    function automatic int route_of(input logic [5:0] id);
        if (id >= 6'd1 && id <= 6'd32) begin
            return int'(id) + 3;
        end
        return 0;
    endfunction

    // Node that owns this address, or -1 when nobody claims it
    function automatic int reference_node(input int addr);
        int node;
        node = -1;
        for (int n = 0; n < noc_pkg::NUM_NODES; n++) begin
            if (addr == int'(noc_pkg::BASE_GPU_ID) + n + 3) begin
                node = n;
            end
        end
        return node;
    endfunction

    // Receiver turns the address back into an ID, payload untouched
    function automatic noc_pkg::flit_t reference_flit(input int addr, input noc_pkg::flit_t sent);
        logic [5:0] id;
        id = 6'(addr - 3);
        return {id, sent[noc_pkg::PAYLOAD_W-1:0]};
    endfunction

    task automatic record_sent(input int src, input noc_pkg::flit_t sent);
        int addr;
        int dst;
        addr = route_of(sent[noc_pkg::FLIT_W-1 -: noc_pkg::HDR_W]);
        dst  = reference_node(addr);
        if (dst < 0) begin
            exp_drops++;
        end else begin
            expected_q[dst][src].push_back(reference_flit(addr, sent));
            pending++;
        end
    endtask

    task automatic check_fairness(input int src);
        logic [noc_pkg::NUM_NODES-1:0] seen;
        fair_window.push_back(src[1:0]);
        if (fair_window.size() > noc_pkg::NUM_NODES) begin
            fair_window.delete(0);
        end
        if (fair_window.size() == noc_pkg::NUM_NODES) begin
            seen = '0;
            foreach (fair_window[i]) begin
                seen[fair_window[i]] = 1'b1;
            end
            if (seen != '1) begin
                $display("round-robin broken at node %0d, last sources %0d %0d %0d %0d",
                         fair_dst, fair_window[0], fair_window[1], fair_window[2],
                         fair_window[3]);
                error_count++;
            end
        end
    endtask

    task automatic compare_received(input int dst, input noc_pkg::flit_t got);
        int             src;
        noc_pkg::flit_t want;
        // Payload tag carries the source node
        src = int'(got[noc_pkg::PAYLOAD_W-1 -: 2]);
        check_count++;
        if (expected_q[dst][src].size() == 0) begin
            $display("node %0d delivered flit %h that no source sent to it", dst, got);
            error_count++;
        end else begin
            want = expected_q[dst][src].pop_front();
            pending--;
            if (got !== want) begin
                $display("error gpu_rx_data[%0d] expected %h got %h", dst, want, got);
                error_count++;
            end
        end
        if (fair_en && dst == fair_dst) begin
            check_fairness(src);
        end
    endtask

    always @(posedge clk) begin
        if (!reset) begin
            for (int s = 0; s < noc_pkg::NUM_NODES; s++) begin
                if (gpu_tx_valid[s] && gpu_tx_ready[s]) begin
                    record_sent(s, gpu_tx_data[s]);
                end
            end
            for (int d = 0; d < noc_pkg::NUM_NODES; d++) begin
                if (gpu_rx_valid[d] && gpu_rx_ready[d]) begin
                    compare_received(d, gpu_rx_data[d]);
                end
            end
            if (gpu_tx_ready != '1) begin
                stall_seen = 1'b1;
            end
        end
    end

    task automatic check_reset_state();
        check_count++;
        if (gpu_rx_valid !== '0) begin
            $display("error gpu_rx_valid expected %h got %h", 4'h0, gpu_rx_valid);
            error_count++;
        end
        if (drop_count !== '0) begin
            $display("error drop_count expected %h got %h", 16'h0, drop_count);
            error_count++;
        end
        if (gpu_tx_ready !== '1) begin
            $display("error gpu_tx_ready expected %h got %h", 4'hf, gpu_tx_ready);
            error_count++;
        end
    endtask

    task automatic compare_drops();
        check_count++;
        if (drop_count !== 16'(exp_drops)) begin
            $display("error drop_count expected %h got %h", 16'(exp_drops), drop_count);
            error_count++;
        end
    endtask

    task automatic clear_stall();
        stall_seen = 1'b0;
    endtask

    task automatic check_stall_seen();
        check_count++;
        if (!stall_seen) begin
            $display("gpu_tx_ready never fell while the receiver held back");
            error_count++;
        end
    endtask

    task automatic start_fairness(input int dst);
        fair_window.delete();
        fair_dst = dst;
        fair_en  = 1'b1;
    endtask

    task automatic stop_fairness();
        fair_en = 1'b0;
    endtask

endmodule

`default_nettype wire

/* testbench/cluster_assert.sv */
`timescale 1ns/100ps
`default_nettype none

module cluster_assert (
    input  wire logic                          clk,
    input  wire logic                          reset,
    input  wire logic [noc_pkg::NUM_NODES-1:0] tx_valid,
    input  wire logic [noc_pkg::NUM_NODES-1:0] tx_ready,
    input  wire logic                          bus_valid,
    input  noc_pkg::flit_t                     bus_data,
    input  wire logic                          complete
);

    // Only the winner is ever released
    single_ready: assert property (@(posedge clk) disable iff (reset)
        $onehot0(tx_ready))
        else $error("more than one tx_ready high, %b", tx_ready);

    // A stalled flit stays on the bus unchanged
    bus_hold: assert property (@(posedge clk) disable iff (reset)
        (bus_valid && !complete) |=> (bus_valid && $stable(bus_data)))
        else $error("bus flit changed before its transfer completed");

    ready_needs_valid: assert property (@(posedge clk) disable iff (reset)
        (tx_ready & ~tx_valid) == '0)
        else $error("tx_ready high without tx_valid, ready %b valid %b", tx_ready, tx_valid);

endmodule

`default_nettype wire

/* testbench/tb_gpu_cluster.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_gpu_cluster;

    localparam logic [31:0] LFSR_SEED      = 32'd66195;
    // x^32 + x^22 + x^2 + x + 1
    localparam logic [31:0] LFSR_TAPS      = 32'h8020_0003;
    localparam int          RESET_CYCLES   = 16;
    localparam int          WAIT_LIMIT     = 2000;
    localparam int          HOLD_CYCLES    = 20;
    localparam int          DELIVERY_FLITS = 24;
    localparam int          PRESSURE_FLITS = 12;
    localparam int          FAIR_FLITS     = 16;

    logic                                    clk = 1'b0;
    logic                                    reset;
    noc_pkg::flit_t [noc_pkg::NUM_NODES-1:0] gpu_tx_data;
    logic           [noc_pkg::NUM_NODES-1:0] gpu_tx_valid;
    logic           [noc_pkg::NUM_NODES-1:0] gpu_tx_ready;
    noc_pkg::flit_t [noc_pkg::NUM_NODES-1:0] gpu_rx_data;
    logic           [noc_pkg::NUM_NODES-1:0] gpu_rx_valid;
    logic           [noc_pkg::NUM_NODES-1:0] gpu_rx_ready;
    logic           [15:0]                   drop_count;

    int             pending;
    int             check_count;
    int             error_count;
    logic [31:0]    lfsr_state;
    noc_pkg::flit_t tx_plan [noc_pkg::NUM_NODES][$];
    int             drivers_busy;
    bit             timed_out;
    int             tests_failed;

    always #2 clk = ~clk;

    gpu_cluster gpu_cluster_inst (
        .clk          (clk),
        .reset        (reset),
        .gpu_tx_data  (gpu_tx_data),
        .gpu_tx_valid (gpu_tx_valid),
        .gpu_tx_ready (gpu_tx_ready),
        .gpu_rx_data  (gpu_rx_data),
        .gpu_rx_valid (gpu_rx_valid),
        .gpu_rx_ready (gpu_rx_ready),
        .drop_count   (drop_count)
    );

    cluster_checker cluster_checker_inst (
        .clk          (clk),
        .reset        (reset),
        .gpu_tx_data  (gpu_tx_data),
        .gpu_tx_valid (gpu_tx_valid),
        .gpu_tx_ready (gpu_tx_ready),
        .gpu_rx_data  (gpu_rx_data),
        .gpu_rx_valid (gpu_rx_valid),
        .gpu_rx_ready (gpu_rx_ready),
        .drop_count   (drop_count),
        .pending      (pending),
        .check_count  (check_count),
        .error_count  (error_count)
    );

    bind bus_arbiter cluster_assert cluster_assert_inst (
        .clk       (clk),
        .reset     (reset),
        .tx_valid  (req),
        .tx_ready  ({links[3].tx_ready, links[2].tx_ready, links[1].tx_ready, links[0].tx_ready}),
        .bus_valid (bus_valid),
        .bus_data  (bus_data),
        .complete  (complete)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ LFSR_TAPS;
        end
        return state >> 1;
    endfunction

    function automatic logic [7:0] take_bits(input int n);
        logic [7:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits       = {bits[6:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return bits;
    endfunction

    // Upper payload bits tag the source node
    function automatic noc_pkg::flit_t make_flit(input int src, input noc_pkg::gpu_id_t dest);
        logic [7:0] noise;
        noise = take_bits(8);
        return {dest, 2'(src), noise};
    endfunction

    task automatic drive_node(input int node);
        noc_pkg::flit_t flit;
        int             waited;
        while (tx_plan[node].size() != 0 && !timed_out) begin
            flit               = tx_plan[node].pop_front();
            gpu_tx_data[node]  = flit;
            gpu_tx_valid[node] = 1'b1;
            waited = 0;
            while (!gpu_tx_ready[node] && waited < WAIT_LIMIT) begin
                @(posedge clk);
                #0.5;
                waited++;
            end
            if (!gpu_tx_ready[node]) begin
                $display("timeout, node %0d gpu_tx_ready stayed low", node);
                timed_out = 1'b1;
            end
            @(posedge clk);
            #0.5;
        end
        gpu_tx_valid[node] = 1'b0;
        drivers_busy--;
    endtask

    task automatic start_drivers();
        for (int n = 0; n < noc_pkg::NUM_NODES; n++) begin
            automatic int node = n;
            drivers_busy++;
            fork
                drive_node(node);
            join_none
        end
    endtask

    task automatic wait_drivers();
        int waited = 0;
        while (drivers_busy != 0 && !timed_out && waited < WAIT_LIMIT) begin
            @(posedge clk);
            #0.5;
            waited++;
        end
        if (drivers_busy != 0 && !timed_out) begin
            $display("timeout, flit drivers did not finish");
            timed_out = 1'b1;
        end
    endtask

    // Everything sent has been delivered or dropped
    task automatic wait_drain();
        int waited = 0;
        while ((pending != 0 || gpu_cluster_inst.bus_arbiter_inst.bus_valid) && !timed_out
               && waited < WAIT_LIMIT) begin
            @(posedge clk);
            #0.5;
            waited++;
        end
        if ((pending != 0 || gpu_cluster_inst.bus_arbiter_inst.bus_valid) && !timed_out) begin
            $display("timeout, %0d flits still in flight", pending);
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_stall();
        int waited = 0;
        while (gpu_tx_ready[2:0] == 3'b111 && !timed_out && waited < WAIT_LIMIT) begin
            @(posedge clk);
            #0.5;
            waited++;
        end
        if (gpu_tx_ready[2:0] == 3'b111 && !timed_out) begin
            $display("timeout, senders never stalled on the blocked receiver");
            timed_out = 1'b1;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (error_count == errors_before && !timed_out) begin
            $display("test %s: pass", name);
        end else begin
            $display("test %s: fail", name);
            tests_failed++;
        end
    endtask

    initial begin
        noc_pkg::gpu_id_t drop_ids [4];
        noc_pkg::gpu_id_t dest;
        int               errors_before;
        drop_ids     = '{6'd0, 6'd5, 6'd33, 6'd63};
        reset        = 1'b1;
        gpu_tx_data  = '0;
        gpu_tx_valid = '0;
        gpu_rx_ready = '1;
        lfsr_state   = LFSR_SEED;
        drivers_busy = 0;
        timed_out    = 1'b0;
        tests_failed = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #0.5;
        reset = 1'b0;
        @(posedge clk);
        #0.5;

        errors_before = error_count;
        cluster_checker_inst.check_reset_state();
        report_test("reset state", errors_before);

        // First round reaches every cluster GPU, the rest is random
        errors_before = error_count;
        for (int n = 0; n < noc_pkg::NUM_NODES; n++) begin
            for (int k = 0; k < DELIVERY_FLITS; k++) begin
                if (k < noc_pkg::NUM_NODES) begin
                    dest = noc_pkg::BASE_GPU_ID + 6'(k);
                end else begin
                    dest = noc_pkg::BASE_GPU_ID + 6'(take_bits(2));
                end
                tx_plan[n].push_back(make_flit(n, dest));
            end
        end
        start_drivers();
        wait_drivers();
        wait_drain();
        cluster_checker_inst.compare_drops();
        report_test("delivery and translation", errors_before);

        errors_before = error_count;
        for (int n = 0; n < noc_pkg::NUM_NODES; n++) begin
            foreach (drop_ids[i]) begin
                tx_plan[n].push_back(make_flit(n, drop_ids[i]));
                dest = noc_pkg::BASE_GPU_ID + 6'(take_bits(2));
                tx_plan[n].push_back(make_flit(n, dest));
            end
        end
        start_drivers();
        wait_drivers();
        wait_drain();
        cluster_checker_inst.compare_drops();
        report_test("drops", errors_before);

        // Node 3 refuses flits until the senders back up
        errors_before = error_count;
        gpu_rx_ready[3] = 1'b0;
        cluster_checker_inst.clear_stall();
        for (int n = 0; n < 3; n++) begin
            for (int k = 0; k < PRESSURE_FLITS; k++) begin
                tx_plan[n].push_back(make_flit(n, noc_pkg::BASE_GPU_ID + 6'd3));
            end
        end
        start_drivers();
        wait_stall();
        repeat (HOLD_CYCLES) @(posedge clk);
        #0.5;
        gpu_rx_ready[3] = 1'b1;
        wait_drivers();
        wait_drain();
        cluster_checker_inst.check_stall_seen();
        report_test("back-pressure", errors_before);

        errors_before = error_count;
        cluster_checker_inst.start_fairness(0);
        for (int n = 0; n < noc_pkg::NUM_NODES; n++) begin
            for (int k = 0; k < FAIR_FLITS; k++) begin
                tx_plan[n].push_back(make_flit(n, noc_pkg::BASE_GPU_ID));
            end
        end
        start_drivers();
        wait_drivers();
        wait_drain();
        cluster_checker_inst.stop_fairness();
        report_test("fairness", errors_before);

        $display("checks %0d, errors %0d, failed tests %0d",
                 check_count, error_count, tests_failed);
        if (error_count == 0 && tests_failed == 0 && !timed_out) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* gpu_cluster.f */
verilog/noc_pkg.sv
verilog/node_link_if.sv
verilog/flit_fifo.sv
verilog/gpu_ni.sv
verilog/bus_arbiter.sv
verilog/gpu_cluster.sv
testbench/cluster_checker.sv
testbench/cluster_assert.sv
testbench/tb_gpu_cluster.sv
